//--- Makefile
SIM     = verilator
FLAGS   = --binary --timing -Wno-fatal
TOP     = femtoCoreTb
FLIST   = femtoCore.f
OBJDIR  = obj_dir
BIN     = $(OBJDIR)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- dv/clockGen.sv
`default_nettype none
`timescale 1ns/10ps

module clockGen (
   output logic clk,
   output logic resetn,
   input  logic reqReset
);

   int   resetLeft = 4;
   logic reqSeen;

   initial begin
      clk    = 1'b0;
      resetn = 1'b0;
   end

   // 4 ns period
   always #2 clk = ~clk;

   // A request restarts a reset of 4 cycles
   always @(posedge clk) begin
      reqSeen = reqReset;
      #1;
      if (reqSeen) begin
         resetLeft = 4;
      end
      if (resetLeft != 0) begin
         resetn    = 1'b0;
         resetLeft = resetLeft - 1;
      end else begin
         resetn = 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- dv/femtoCoreTb.sv
`default_nettype none
`timescale 1ns/10ps

module femtoCoreTb;

   import memBusPkg::*;

   // Full 7-bit opcodes
   localparam logic [6:0] opcR     = 7'h33;
   localparam logic [6:0] opcI     = 7'h13;
   localparam logic [6:0] opcLd    = 7'h03;
   localparam logic [6:0] opcJalr  = 7'h67;
   localparam logic [6:0] opcLui   = 7'h37;
   localparam logic [6:0] opcAuipc = 7'h17;
   localparam logic [6:0] opcSys   = 7'h73;
   // Row kinds for the program builder
   localparam int kindSingle = 0;
   localparam int kindBranch = 1;
   localparam int kindCycle  = 2;

   logic        clk;
   logic        resetn;
   logic        reqReset = 1'b0;
   memReq_t     memReq;
   memRsp_t     memRsp = '0;
   logic [31:0] mem [1024];
   memReq_t     reqS;
   logic        rstnS;
   logic        prevWrite = 1'b0;
   logic [1:0]  rLeft = '0;
   logic [1:0]  wLeft = '0;
   logic [31:0] rdataR = '0;
   logic [31:0] rnd;
   integer      seed = 72;
   logic        storeSeen = 1'b0;
   logic [3:0]  seenMask;
   logic [31:0] seenData;
   int          checks = 0;
   int          errors = 0;
   int          timeouts = 0;

   // Test table
   string       rowName [$];
   logic [31:0] rowOp1 [$];
   logic [31:0] rowOp2 [$];
   logic [31:0] rowInstr [$];
   int          rowKind [$];
   logic [31:0] rowExp [$];
   logic [3:0]  rowMask [$];

   clockGen i_clockGen (
      .clk      (clk),
      .resetn   (resetn),
      .reqReset (reqReset)
   );

   femtoCore #(
      .resetAddr  (32'h0000_0000),
      .cycleWidth (24)
   ) i_femtoCore (
      .clk    (clk),
      .resetn (resetn),
      .memReq (memReq),
      .memRsp (memRsp)
   );

   function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, opcR};
   endfunction

   function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] encodeB(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] encodeU(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] encodeJ(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
   endfunction

   // LUI part rounded for the sign of the following ADDI
   function automatic logic [19:0] upperPart(input logic [31:0] v);
      logic [31:0] sum;
      sum = v + 32'h800;
      return sum[31:12];
   endfunction

   task automatic addRow(input string name, input logic [31:0] op1, input logic [31:0] op2,
                         input logic [31:0] instr, input int kind, input logic [31:0] expVal,
                         input logic [3:0] expMask);
      rowName.push_back(name);
      rowOp1.push_back(op1);
      rowOp2.push_back(op2);
      rowInstr.push_back(instr);
      rowKind.push_back(kind);
      rowExp.push_back(expVal);
      rowMask.push_back(expMask);
   endtask

   task automatic buildTable();
      logic [31:0] a;
      logic [31:0] b;
      a = 32'h8000_0010;
      b = 32'h0000_0003;
      // Register ALU ops on a negative and a small operand
      addRow("ADD", a, b, encodeR(7'h00, 2, 1, 3'd0, 3), kindSingle, 32'h8000_0013, 4'hF);
      addRow("SUB", a, b, encodeR(7'h20, 2, 1, 3'd0, 3), kindSingle, 32'h8000_000D, 4'hF);
      addRow("SLL", a, b, encodeR(7'h00, 2, 1, 3'd1, 3), kindSingle, 32'h0000_0080, 4'hF);
      addRow("SLT", a, b, encodeR(7'h00, 2, 1, 3'd2, 3), kindSingle, 32'h1, 4'hF);
      addRow("SLT rev", a, b, encodeR(7'h00, 1, 2, 3'd2, 3), kindSingle, 32'h0, 4'hF);
      addRow("SLTU", a, b, encodeR(7'h00, 2, 1, 3'd3, 3), kindSingle, 32'h0, 4'hF);
      addRow("SLTU rev", a, b, encodeR(7'h00, 1, 2, 3'd3, 3), kindSingle, 32'h1, 4'hF);
      addRow("XOR", a, b, encodeR(7'h00, 2, 1, 3'd4, 3), kindSingle, 32'h8000_0013, 4'hF);
      addRow("SRL", a, b, encodeR(7'h00, 2, 1, 3'd5, 3), kindSingle, 32'h1000_0002, 4'hF);
      addRow("SRA", a, b, encodeR(7'h20, 2, 1, 3'd5, 3), kindSingle, 32'hF000_0002, 4'hF);
      addRow("OR", a, b, encodeR(7'h00, 2, 1, 3'd6, 3), kindSingle, 32'h8000_0013, 4'hF);
      addRow("AND", a, 32'hFFFF_00F0, encodeR(7'h00, 2, 1, 3'd7, 3), kindSingle,
             32'h8000_0010, 4'hF);
      // ADDI with bit 30 set must still add
      addRow("ADDI", a, b, encodeI(12'hFFF, 1, 3'd0, 3, opcI), kindSingle, 32'h8000_000F, 4'hF);
      addRow("SLTI", a, b, encodeI(12'hFFF, 1, 3'd2, 3, opcI), kindSingle, 32'h1, 4'hF);
      addRow("SLTIU", a, b, encodeI(12'hFFF, 1, 3'd3, 3, opcI), kindSingle, 32'h1, 4'hF);
      addRow("XORI", a, b, encodeI(12'h7FF, 1, 3'd4, 3, opcI), kindSingle, 32'h8000_07EF, 4'hF);
      addRow("ORI", a, b, encodeI(12'h00F, 1, 3'd6, 3, opcI), kindSingle, 32'h8000_001F, 4'hF);
      addRow("ANDI", a, b, encodeI(12'h0F0, 1, 3'd7, 3, opcI), kindSingle, 32'h10, 4'hF);
      addRow("SLLI", a, b, encodeI(12'h004, 1, 3'd1, 3, opcI), kindSingle, 32'h100, 4'hF);
      addRow("SRLI", a, b, encodeI(12'h004, 1, 3'd5, 3, opcI), kindSingle, 32'h0800_0001, 4'hF);
      addRow("SRAI", a, b, encodeI(12'h404, 1, 3'd5, 3, opcI), kindSingle, 32'hF800_0001, 4'hF);
      // Branch to +12 stores 2 and fall through stores 1
      addRow("BEQ nt", a, b, encodeB(13'd12, 2, 1, 3'd0), kindBranch, 32'd1, 4'hF);
      addRow("BEQ t", a, b, encodeB(13'd12, 1, 1, 3'd0), kindBranch, 32'd2, 4'hF);
      addRow("BNE t", a, b, encodeB(13'd12, 2, 1, 3'd1), kindBranch, 32'd2, 4'hF);
      addRow("BNE nt", a, b, encodeB(13'd12, 1, 1, 3'd1), kindBranch, 32'd1, 4'hF);
      addRow("BLT t", a, b, encodeB(13'd12, 2, 1, 3'd4), kindBranch, 32'd2, 4'hF);
      addRow("BLT nt", a, b, encodeB(13'd12, 1, 2, 3'd4), kindBranch, 32'd1, 4'hF);
      addRow("BGE nt", a, b, encodeB(13'd12, 2, 1, 3'd5), kindBranch, 32'd1, 4'hF);
      addRow("BGE t", a, b, encodeB(13'd12, 1, 2, 3'd5), kindBranch, 32'd2, 4'hF);
      addRow("BLTU nt", a, b, encodeB(13'd12, 2, 1, 3'd6), kindBranch, 32'd1, 4'hF);
      addRow("BLTU t", a, b, encodeB(13'd12, 1, 2, 3'd6), kindBranch, 32'd2, 4'hF);
      addRow("BGEU t", a, b, encodeB(13'd12, 2, 1, 3'd7), kindBranch, 32'd2, 4'hF);
      addRow("BGEU nt", a, b, encodeB(13'd12, 1, 2, 3'd7), kindBranch, 32'd1, 4'hF);
      // Jumps sit at address 16 so the link is 20
      addRow("JAL", a, b, encodeJ(21'd8, 3), kindSingle, 32'd20, 4'hF);
      addRow("JALR", 32'd24, b, encodeI(12'h0, 1, 3'd0, 3, opcJalr), kindSingle, 32'd20, 4'hF);
      addRow("LUI", a, b, encodeU(20'hABCDE, 3, opcLui), kindSingle, 32'hABCD_E000, 4'hF);
      addRow("AUIPC", a, b, encodeU(20'h12345, 3, opcAuipc), kindSingle, 32'h1234_5010, 4'hF);
      // Loads from the word 8123F4A5 at 0x200
      addRow("LB 0", 32'h200, b, encodeI(12'd0, 1, 3'd0, 3, opcLd), kindSingle,
             32'hFFFF_FFA5, 4'hF);
      addRow("LB 1", 32'h200, b, encodeI(12'd1, 1, 3'd0, 3, opcLd), kindSingle,
             32'hFFFF_FFF4, 4'hF);
      addRow("LB 2", 32'h200, b, encodeI(12'd2, 1, 3'd0, 3, opcLd), kindSingle, 32'h23, 4'hF);
      addRow("LB 3", 32'h200, b, encodeI(12'd3, 1, 3'd0, 3, opcLd), kindSingle,
             32'hFFFF_FF81, 4'hF);
      addRow("LBU 1", 32'h200, b, encodeI(12'd1, 1, 3'd4, 3, opcLd), kindSingle, 32'hF4, 4'hF);
      addRow("LBU 3", 32'h200, b, encodeI(12'd3, 1, 3'd4, 3, opcLd), kindSingle, 32'h81, 4'hF);
      addRow("LH 0", 32'h200, b, encodeI(12'd0, 1, 3'd1, 3, opcLd), kindSingle,
             32'hFFFF_F4A5, 4'hF);
      addRow("LH 2", 32'h200, b, encodeI(12'd2, 1, 3'd1, 3, opcLd), kindSingle,
             32'hFFFF_8123, 4'hF);
      addRow("LHU 0", 32'h200, b, encodeI(12'd0, 1, 3'd5, 3, opcLd), kindSingle, 32'hF4A5, 4'hF);
      addRow("LHU 2", 32'h200, b, encodeI(12'd2, 1, 3'd5, 3, opcLd), kindSingle, 32'h8123, 4'hF);
      addRow("LW", 32'h200, b, encodeI(12'd0, 1, 3'd2, 3, opcLd), kindSingle, 32'h8123_F4A5, 4'hF);
      // Stores of 11223344 based at 0x100 where the first write is checked
      addRow("SB 0", 32'h100, 32'h1122_3344, encodeS(12'd0, 2, 1, 3'd0), kindSingle,
             32'h0000_0044, 4'b0001);
      addRow("SB 1", 32'h100, 32'h1122_3344, encodeS(12'd1, 2, 1, 3'd0), kindSingle,
             32'h0000_4400, 4'b0010);
      addRow("SB 2", 32'h100, 32'h1122_3344, encodeS(12'd2, 2, 1, 3'd0), kindSingle,
             32'h0044_0000, 4'b0100);
      addRow("SB 3", 32'h100, 32'h1122_3344, encodeS(12'd3, 2, 1, 3'd0), kindSingle,
             32'h4400_0000, 4'b1000);
      addRow("SH 0", 32'h100, 32'h1122_3344, encodeS(12'd0, 2, 1, 3'd1), kindSingle,
             32'h0000_3344, 4'b0011);
      addRow("SH 2", 32'h100, 32'h1122_3344, encodeS(12'd2, 2, 1, 3'd1), kindSingle,
             32'h3344_0000, 4'b1100);
      addRow("SW", 32'h100, 32'h1122_3344, encodeS(12'd0, 2, 1, 3'd2), kindSingle,
             32'h1122_3344, 4'b1111);
      // Difference of two counter reads
      addRow("RDCYCLE", a, b, 32'h0, kindCycle, 32'h0, 4'hF);
   endtask

   task automatic loadProgram(input int r);
      logic [31:0] nop;
      nop = encodeI(12'h0, 0, 3'd0, 0, opcI);
      // Background pattern from the whole word index
      for (int i = 0; i < 1024; i++) begin
         mem[i] = 32'hA5C3_0000 | 32'(i);
      end
      mem[0] = encodeU(upperPart(rowOp1[r]), 1, opcLui);
      mem[1] = encodeI(rowOp1[r][11:0], 1, 3'd0, 1, opcI);
      mem[2] = encodeU(upperPart(rowOp2[r]), 2, opcLui);
      mem[3] = encodeI(rowOp2[r][11:0], 2, 3'd0, 2, opcI);
      mem[4] = rowInstr[r];
      mem[5] = nop;
      mem[6] = nop;
      mem[7] = nop;
      if (rowKind[r] == kindBranch) begin
         mem[5] = encodeI(12'd1, 0, 3'd0, 3, opcI);
         mem[6] = encodeJ(21'd8, 0);
         mem[7] = encodeI(12'd2, 0, 3'd0, 3, opcI);
      end else if (rowKind[r] == kindCycle) begin
         // Two rdcycle reads into x3 and x4 then their difference in x3
         mem[4] = encodeI(12'hC00, 0, 3'd2, 3, opcSys);
         mem[5] = encodeI(12'hC00, 0, 3'd2, 4, opcSys);
         mem[6] = encodeR(7'h20, 3, 4, 3'd0, 3);
      end
      mem[8] = encodeS(12'h100, 3, 0, 3'd2);
      // Park on a self-jump
      mem[9] = encodeJ(21'd0, 0);
      mem[10'h080] = 32'h8123_F4A5;
   endtask

   task automatic commitWrite(input memReq_t req);
      logic [9:0] idx;
      idx = req.addr[11:2];
      for (int lane = 0; lane < 4; lane++) begin
         if (req.wmask[lane]) begin
            mem[idx][8*lane +: 8] = req.wdata[8*lane +: 8];
         end
      end
      // Only the first write to 0x100 is kept for checking
      if (idx == 10'h040 && !storeSeen) begin
         storeSeen = 1'b1;
         seenMask  = req.wmask;
         seenData  = req.wdata;
      end
   endtask

   // Memory model samples the request at the edge and drives the response after it
   always @(posedge clk) begin
      reqS  = memReq;
      rstnS = resetn;
      #1;
      if (!rstnS) begin
         rLeft     = '0;
         wLeft     = '0;
         prevWrite = 1'b0;
      end else begin
         if (reqS.rstrb) begin
            rdataR = mem[reqS.addr[11:2]];
            rnd    = $random(seed);
            rLeft  = rnd[1:0];
         end else if (rLeft != 0) begin
            rLeft = rLeft - 2'd1;
         end
         // Commit on the first cycle of a nonzero mask
         if (reqS.wmask != 4'b0 && !prevWrite) begin
            commitWrite(reqS);
            rnd   = $random(seed);
            wLeft = rnd[1:0];
         end else if (wLeft != 0) begin
            wLeft = wLeft - 2'd1;
         end
         prevWrite = (reqS.wmask != 4'b0);
      end
      memRsp.rdata = rdataR;
      memRsp.rbusy = (rLeft != 0);
      memRsp.wbusy = (wLeft != 0);
   end

   task automatic checkRow(input int r);
      logic [31:0] lanes;
      // Byte lanes the expected mask says are written
      lanes = {{8{rowMask[r][3]}}, {8{rowMask[r][2]}}, {8{rowMask[r][1]}}, {8{rowMask[r][0]}}};
      checks++;
      if (rowKind[r] == kindCycle) begin
         if (seenData == 32'h0 || seenData >= 32'd64) begin
            errors++;
            $display("CHECK FAILED at %0t: %s difference %0d not small and positive",
                     $time, rowName[r], seenData);
         end
      end else begin
         if (seenMask != rowMask[r]) begin
            errors++;
            $display("CHECK FAILED at %0t: %s mask %b expected %b",
                     $time, rowName[r], seenMask, rowMask[r]);
         end
         if ((seenData & lanes) != rowExp[r]) begin
            errors++;
            $display("CHECK FAILED at %0t: %s data %h expected %h",
                     $time, rowName[r], seenData & lanes, rowExp[r]);
         end
      end
   endtask

   task automatic runRow(input int r);
      int waited;
      @(posedge clk);
      #1;
      reqReset = 1'b1;
      @(posedge clk);
      #1;
      reqReset = 1'b0;
      waited = 0;
      while (resetn && waited < 20) begin
         @(posedge clk);
         waited++;
      end
      if (resetn) begin
         timeouts++;
         $display("Reset never went low for row %s", rowName[r]);
         return;
      end
      // Program is loaded while the core is held in reset
      loadProgram(r);
      storeSeen = 1'b0;
      waited = 0;
      while (!resetn && waited < 20) begin
         @(posedge clk);
         waited++;
      end
      if (!resetn) begin
         timeouts++;
         $display("Reset never released for row %s", rowName[r]);
         return;
      end
      waited = 0;
      while (!storeSeen && waited < 400) begin
         @(posedge clk);
         waited++;
      end
      if (!storeSeen) begin
         timeouts++;
         $display("No write to address 0x100 within 400 cycles for row %s", rowName[r]);
         return;
      end
      checkRow(r);
   endtask

   initial begin
      buildTable();
      for (int r = 0; r < rowName.size(); r++) begin
         runRow(r);
      end
      $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- femtoCore.f
verilog/rvIsaPkg.sv
verilog/memBusPkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/loadStoreAlign.sv
verilog/coreControl.sv
verilog/femtoCore.sv
dv/clockGen.sv
dv/femtoCoreTb.sv

//--- verilog/coreControl.sv
`default_nettype none
`timescale 1ns/10ps

module coreControl #(
   parameter logic [31:0] resetAddr  = 32'h0000_0000,
   parameter int unsigned cycleWidth = 32
) (
   input  logic                            clk,
   input  logic                            resetn,
   input  memBusPkg::memRsp_t              memRsp,
   input  rvIsaPkg::decoded_t              dec,
   input  rvIsaPkg::imms_t                 imms,
   input  logic [rvIsaPkg::xlen-1:0]       aluPlus,
   input  logic [rvIsaPkg::xlen-1:0]       aluOut,
   input  logic [rvIsaPkg::xlen-1:0]       loadData,
   input  logic [rvIsaPkg::xlen-1:0]       wdata,
   input  logic [memBusPkg::maskWidth-1:0] storeMask,
   input  logic                            takeBranch,
   output rvIsaPkg::instr_t                instr,
   output logic [rvIsaPkg::xlen-1:0]       pc,
   output logic                            rdEn,
   output logic                            wbEn,
   output logic [rvIsaPkg::xlen-1:0]       wbData,
   output memBusPkg::memReq_t              memReq
);

   import rvIsaPkg::*;
   import memBusPkg::*;

   // One-hot state bit positions
   localparam int fetchBit   = 0;
   localparam int waitInstrBit = 1;
   localparam int executeBit = 2;
   localparam int waitMemBit = 3;

   logic [3:0]            state;
   logic [cycleWidth-1:0] cycles;
   logic [xlen-1:0]       cycleWord;
   logic [xlen-1:0]       pcPlus4;
   logic [xlen-1:0]       pcNext;
   logic                  needToWait;
   logic                  inStore;

   assign pcPlus4 = pc + 32'd4;
   // Jump target from the adder, bit 0 cleared for JALR
   assign pcNext  = takeBranch ? {aluPlus[xlen-1:1], 1'b0} : pcPlus4;
   assign needToWait = dec.isLoad | dec.isStore;

   // Narrow counter zero extended to the word
   assign cycleWord = xlen'(cycles);

   // Write-back source, one group active at a time
   assign wbData = (dec.isSystem              ? cycleWord : '0) |
                   (dec.isLui                 ? imms.u    : '0) |
                   (dec.isAlu                 ? aluOut    : '0) |
                   (dec.isAuipc               ? aluPlus   : '0) |
                   (dec.isJal | dec.isJalr    ? pcPlus4   : '0) |
                   (dec.isLoad                ? loadData  : '0);

   // Branches and stores have no destination
   assign wbEn = ~(dec.isBranch | dec.isStore) & (state[executeBit] | state[waitMemBit]);
   // Sources latched when the fetched word is valid
   assign rdEn = state[waitInstrBit] & ~memRsp.rbusy;

   // Fetch at PC, prefetch next PC for non-memory ops, else the data address
   assign memReq.addr  = (state[fetchBit] | state[waitInstrBit])  ? pc     :
                         (state[executeBit] & ~needToWait)        ? pcNext :
                                                                    aluPlus;
   assign memReq.wdata = wdata;
   assign inStore      = (state[executeBit] | state[waitMemBit]) & dec.isStore;
   assign memReq.wmask = {maskWidth{inStore}} & storeMask;
   // Store is the only EXECUTE without a read
   assign memReq.rstrb = (state[executeBit] & ~dec.isStore) | state[fetchBit];

   always_ff @(posedge clk) begin
      if (!resetn) begin
         // Start by draining any pending memory access
         state <= 4'b1 << waitMemBit;
         pc    <= resetAddr;
         // Unknown opcode with rd zero, harmless write-back
         instr <= 30'd1;
      end else begin
         case (1'b1)
            state[waitInstrBit]: begin
               if (!memRsp.rbusy) begin
                  instr <= memRsp.rdata[31:2];
                  state <= 4'b1 << executeBit;
               end
            end
            state[executeBit]: begin
               pc    <= pcNext;
               state <= needToWait ? (4'b1 << waitMemBit) : (4'b1 << waitInstrBit);
            end
            state[waitMemBit]: begin
               if (!memRsp.rbusy && !memRsp.wbusy) begin
                  state <= 4'b1 << fetchBit;
               end
            end
            // FETCH
            default: begin
               state <= 4'b1 << waitInstrBit;
            end
         endcase
      end
   end

   // Free-running cycle counter
   always_ff @(posedge clk) begin
      if (!resetn) begin
         cycles <= '0;
      end else begin
         cycles <= cycles + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- verilog/execUnit.sv
`default_nettype none
`timescale 1ns/10ps

module execUnit (
   input  rvIsaPkg::decoded_t        dec,
   input  rvIsaPkg::imms_t           imms,
   input  logic [rvIsaPkg::xlen-1:0] rs1,
   input  logic [rvIsaPkg::xlen-1:0] rs2,
   input  logic [rvIsaPkg::xlen-1:0] pc,
   output logic [rvIsaPkg::xlen-1:0] aluPlus,
   output logic [rvIsaPkg::xlen-1:0] aluOut,
   output logic                      takeBranch
);

   import rvIsaPkg::*;

   logic [xlen-1:0]   aluIn2;
   logic [xlen-1:0]   plusIn1;
   logic [xlen-1:0]   plusIn2;
   logic [xlen:0]     aluMinus;
   logic              lt;
   logic              ltu;
   logic              eq;
   logic [xlen-1:0]   rs1Rev;
   logic [xlen-1:0]   shiftIn;
   logic signed [xlen:0] shiftExt;
   logic [xlen-1:0]   shifter;
   logic [xlen-1:0]   leftShift;
   logic              predicate;

   // Second ALU operand is rs2 for register ops and branches
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2 : imms.i;

   // Shared adder for ALU add, addresses and jump targets
   assign plusIn1 = (dec.isAlu | dec.isStore | dec.isLoad | dec.isJalr) ? rs1 : pc;
   assign plusIn2 = dec.isStore  ? imms.s :
                    dec.isJal    ? imms.j :
                    dec.isAuipc  ? imms.u :
                    dec.isBranch ? imms.b :
                    dec.isAluReg ? rs2    :
                                   imms.i;
   assign aluPlus = plusIn1 + plusIn2;

   // Borrow of the 33-bit subtract gives unsigned less-than
   assign aluMinus = {1'b0, rs1} - {1'b0, aluIn2};
   // Signs differ so rs1 negative means less
   assign lt  = (rs1[xlen-1] ^ aluIn2[xlen-1]) ? rs1[xlen-1] : aluMinus[xlen];
   assign ltu = aluMinus[xlen];
   assign eq  = (aluMinus[xlen-1:0] == '0);

   // Left shifts reuse the right shifter on reversed bits
   assign rs1Rev    = {<<{rs1}};
   assign shiftIn   = dec.funct3Is[1] ? rs1Rev : rs1;
   // Extra top bit carries the sign for SRA only
   assign shiftExt  = $signed({dec.arith & rs1[xlen-1], shiftIn}) >>> aluIn2[4:0];
   assign shifter   = shiftExt[xlen-1:0];
   assign leftShift = {<<{shifter}};

   always_comb begin
      case (1'b1)
         // SUB only in register form since bit 30 is an immediate bit for ADDI
         dec.funct3Is[0]: aluOut = (dec.arith & dec.regForm) ? aluMinus[xlen-1:0] : aluPlus;
         dec.funct3Is[1]: aluOut = leftShift;
         dec.funct3Is[2]: aluOut = {{(xlen-1){1'b0}}, lt};
         dec.funct3Is[3]: aluOut = {{(xlen-1){1'b0}}, ltu};
         dec.funct3Is[4]: aluOut = rs1 ^ aluIn2;
         // SRL and SRA
         dec.funct3Is[5]: aluOut = shifter;
         dec.funct3Is[6]: aluOut = rs1 | aluIn2;
         default:         aluOut = rs1 & aluIn2;
      endcase
   end

   // No branch uses funct3 2 or 3
   always_comb begin
      case (1'b1)
         dec.funct3Is[0]: predicate = eq;
         dec.funct3Is[1]: predicate = ~eq;
         dec.funct3Is[4]: predicate = lt;
         dec.funct3Is[5]: predicate = ~lt;
         dec.funct3Is[6]: predicate = ltu;
         dec.funct3Is[7]: predicate = ~ltu;
         default:         predicate = 1'b0;
      endcase
   end

   assign takeBranch = dec.isJal | dec.isJalr | (dec.isBranch & predicate);

endmodule

`default_nettype wire

//--- verilog/femtoCore.sv
`default_nettype none
`timescale 1ns/10ps

module femtoCore #(
   parameter logic [31:0] resetAddr  = 32'h0000_0000,
   parameter int unsigned cycleWidth = 32
) (
   input  logic                clk,
   input  logic                resetn,
   output memBusPkg::memReq_t  memReq,
   input  memBusPkg::memRsp_t  memRsp
);

   import rvIsaPkg::*;

   instr_t          instr;
   decoded_t        dec;
   imms_t           imms;
   logic [xlen-1:0] rs1;
   logic [xlen-1:0] rs2;
   logic [xlen-1:0] pc;
   logic [xlen-1:0] aluPlus;
   logic [xlen-1:0] aluOut;
   logic            takeBranch;
   logic [xlen-1:0] loadData;
   logic [xlen-1:0] wdata;
   logic [3:0]      storeMask;
   logic            rdEn;
   logic            wbEn;
   logic [xlen-1:0] wbData;

   instrDecoder i_instrDecoder (
      .instr (instr),
      .dec   (dec),
      .imms  (imms)
   );

   // Source indices come straight from the incoming instruction word
   regFile i_regFile (
      .clk     (clk),
      .rdAddr1 (memRsp.rdata[19:15]),
      .rdAddr2 (memRsp.rdata[24:20]),
      .rdEn    (rdEn),
      .wrEn    (wbEn),
      .wrId    (dec.rdId),
      .wrData  (wbData),
      .rs1     (rs1),
      .rs2     (rs2)
   );

   execUnit i_execUnit (
      .dec        (dec),
      .imms       (imms),
      .rs1        (rs1),
      .rs2        (rs2),
      .pc         (pc),
      .aluPlus    (aluPlus),
      .aluOut     (aluOut),
      .takeBranch (takeBranch)
   );

   // Load/store address is the adder output
   loadStoreAlign i_loadStoreAlign (
      .dec       (dec),
      .addrLo    (aluPlus[1:0]),
      .rdata     (memRsp.rdata),
      .rs2       (rs2),
      .loadData  (loadData),
      .wdata     (wdata),
      .storeMask (storeMask)
   );

   coreControl #(
      .resetAddr  (resetAddr),
      .cycleWidth (cycleWidth)
   ) i_coreControl (
      .clk        (clk),
      .resetn     (resetn),
      .memRsp     (memRsp),
      .dec        (dec),
      .imms       (imms),
      .aluPlus    (aluPlus),
      .aluOut     (aluOut),
      .loadData   (loadData),
      .wdata      (wdata),
      .storeMask  (storeMask),
      .takeBranch (takeBranch),
      .instr      (instr),
      .pc         (pc),
      .rdEn       (rdEn),
      .wbEn       (wbEn),
      .wbData     (wbData),
      .memReq     (memReq)
   );

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`default_nettype none
`timescale 1ns/10ps

module instrDecoder (
   input  rvIsaPkg::instr_t   instr,
   output rvIsaPkg::decoded_t dec,
   output rvIsaPkg::imms_t    imms
);

   import rvIsaPkg::*;

   logic [4:0] opcode;

   assign opcode = instr[6:2];

   // One flag per major opcode
   assign dec.isLoad   = (opcode == opLoad);
   assign dec.isAluImm = (opcode == opAluImm);
   assign dec.isAuipc  = (opcode == opAuipc);
   assign dec.isStore  = (opcode == opStore);
   assign dec.isAluReg = (opcode == opAluReg);
   assign dec.isLui    = (opcode == opLui);
   assign dec.isBranch = (opcode == opBranch);
   assign dec.isJalr   = (opcode == opJalr);
   assign dec.isJal    = (opcode == opJal);
   assign dec.isSystem = (opcode == opSystem);
   assign dec.isAlu    = dec.isAluImm | dec.isAluReg;

   assign dec.rdId     = instr[11:7];
   // One-hot funct3 keeps the ALU and branch muxes flat
   assign dec.funct3Is = 8'b0000_0001 << instr[14:12];
   assign dec.arith    = instr[30];
   // Set for OP, clear for OP-IMM
   assign dec.regForm  = instr[5];

   // Immediates in RISC-V bit order, sign bit is instr[31]
   assign imms.i = {{21{instr[31]}}, instr[30:20]};
   assign imms.s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign imms.b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imms.j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   // Upper immediate, low 12 bits zero
   assign imms.u = {instr[31:12], 12'b0};

endmodule

`default_nettype wire

//--- verilog/loadStoreAlign.sv
`default_nettype none
`timescale 1ns/10ps

module loadStoreAlign (
   input  rvIsaPkg::decoded_t                dec,
   input  logic [1:0]                        addrLo,
   input  logic [rvIsaPkg::xlen-1:0]         rdata,
   input  logic [rvIsaPkg::xlen-1:0]         rs2,
   output logic [rvIsaPkg::xlen-1:0]         loadData,
   output logic [rvIsaPkg::xlen-1:0]         wdata,
   output logic [memBusPkg::maskWidth-1:0]   storeMask
);

   logic        byteAccess;
   logic        halfAccess;
   logic        isUnsigned;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // funct3[1:0] gives the size, 00 byte and 01 halfword
   assign byteAccess = dec.funct3Is[0] | dec.funct3Is[4];
   assign halfAccess = dec.funct3Is[1] | dec.funct3Is[5];
   // funct3[2] set means zero extension
   assign isUnsigned = |dec.funct3Is[7:4];

   // Halfword by bit 1, then byte within it by bit 0
   assign loadHalf = addrLo[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = addrLo[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = ~isUnsigned & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rdata;

   // Low bytes copied to every lane they can land in
   // The mask then picks the lane that is written
   assign wdata[7:0]   = rs2[7:0];
   assign wdata[15:8]  = addrLo[0] ? rs2[7:0] : rs2[15:8];
   assign wdata[23:16] = addrLo[1] ? rs2[7:0] : rs2[23:16];
   assign wdata[31:24] = addrLo[0] ? rs2[7:0] :
                         addrLo[1] ? rs2[15:8] :
                                     rs2[31:24];

   always_comb begin
      if (byteAccess) begin
         // One lane per byte offset
         storeMask = 4'b0001 << addrLo;
      end else if (halfAccess) begin
         storeMask = addrLo[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

`default_nettype wire

//--- verilog/memBusPkg.sv
`default_nettype none

package memBusPkg;

   // Bus word and byte-lane mask widths
   localparam int wordWidth = 32;
   localparam int maskWidth = wordWidth / 8;

   // Core to memory
   typedef struct packed {
      logic [wordWidth-1:0] addr;
      logic [wordWidth-1:0] wdata;
      // One bit per byte lane, nonzero means write
      logic [maskWidth-1:0] wmask;
      // One-cycle read request
      logic                 rstrb;
   } memReq_t;

   // Memory to core
   typedef struct packed {
      logic [wordWidth-1:0] rdata;
      logic                 rbusy;
      logic                 wbusy;
   } memRsp_t;

endpackage

`default_nettype wire

//--- verilog/regFile.sv
`default_nettype none
`timescale 1ns/10ps

module regFile (
   input  logic                     clk,
   input  rvIsaPkg::regIdx_t        rdAddr1,
   input  rvIsaPkg::regIdx_t        rdAddr2,
   input  logic                     rdEn,
   input  logic                     wrEn,
   input  rvIsaPkg::regIdx_t        wrId,
   input  logic [rvIsaPkg::xlen-1:0] wrData,
   output logic [rvIsaPkg::xlen-1:0] rs1,
   output logic [rvIsaPkg::xlen-1:0] rs2
);

   import rvIsaPkg::*;

   // All registers power up at zero
   logic [xlen-1:0] regs [32] = '{default: '0};

   always_ff @(posedge clk) begin
      // x0 is never written so it reads zero
      if (wrEn && (wrId != '0)) begin
         regs[wrId] <= wrData;
      end
      // Sources latched as the instruction arrives
      if (rdEn) begin
         rs1 <= regs[rdAddr1];
         rs2 <= regs[rdAddr2];
      end
   end

endmodule

`default_nettype wire

//--- verilog/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

   // Data word width
   localparam int xlen = 32;

   // Register number
   typedef logic [4:0] regIdx_t;

   // Major opcodes, instruction bits 6 to 2
   localparam logic [4:0] opLoad   = 5'b00000;
   localparam logic [4:0] opAluImm = 5'b00100;
   localparam logic [4:0] opAuipc  = 5'b00101;
   localparam logic [4:0] opStore  = 5'b01000;
   localparam logic [4:0] opAluReg = 5'b01100;
   localparam logic [4:0] opLui    = 5'b01101;
   localparam logic [4:0] opBranch = 5'b11000;
   localparam logic [4:0] opJalr   = 5'b11001;
   localparam logic [4:0] opJal    = 5'b11011;
   localparam logic [4:0] opSystem = 5'b11100;

   // Latched instruction, bits 1 and 0 are always 11 in RV32I
   typedef logic [31:2] instr_t;

   // Decoded instruction
   typedef struct packed {
      logic       isLoad;
      logic       isAluImm;
      logic       isAuipc;
      logic       isStore;
      logic       isAluReg;
      logic       isLui;
      logic       isBranch;
      logic       isJalr;
      logic       isJal;
      logic       isSystem;
      logic       isAlu;
      regIdx_t    rdId;
      // funct3Is[n] set when funct3 == n
      logic [7:0] funct3Is;
      // Instr bit 30, SUB and SRA
      logic       arith;
      // Instr bit 5, register form of ALU ops
      logic       regForm;
   } decoded_t;

   // The five immediate formats, all sign extended
   typedef struct packed {
      logic [xlen-1:0] i;
      logic [xlen-1:0] s;
      logic [xlen-1:0] b;
      logic [xlen-1:0] j;
      logic [xlen-1:0] u;
   } imms_t;

endpackage

`default_nettype wire
